//--- Makefile
TOP = tb_hist_accum

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f sim.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- common/hist_pkg.sv
// shared widths, bank count and vote operation codes for the histogram accumulator
package hist_pkg;

    // --------------------------------------------------
    // banking
    // --------------------------------------------------

    // number of accumulator banks, must be a power of two
    localparam int NUM_BANKS = 4;

    // bank index comes from the low bits of the bin
    localparam int BANK_SEL_WIDTH = $clog2(NUM_BANKS);

    // local address inside one bank
    localparam int BANK_ADDR_WIDTH = 6;

    // words per bank RAM
    localparam int BANK_DEPTH = 1 << BANK_ADDR_WIDTH;

    // global bin number, bank index in the low bits
    localparam int BIN_WIDTH = BANK_SEL_WIDTH + BANK_ADDR_WIDTH;

    // --------------------------------------------------
    // data
    // --------------------------------------------------

    // bin count and vote weight, arithmetic wraps at this width
    localparam int DATA_WIDTH = 18;

    // vote operation codes
    localparam logic OP_ADD = 1'b0;
    localparam logic OP_SUB = 1'b1;

    // --------------------------------------------------
    // timing
    // --------------------------------------------------

    // cycles from a host read strobe until mem_dout may be sampled
    localparam int READ_LATENCY = 4;

endpackage

//--- hist_bank/hist_bank.sv
// one accumulator bank: read-modify-write pipeline with forwarding, bin RAM and running maximum
module hist_bank (
    input  logic                                clk,
    input  logic                                reset,

    // strobes from the dispatcher, one cycle each
    input  logic                                acc_valid,
    input  logic                                mem_en,
    input  logic                                mem_we,

    // shared buses
    input  logic [hist_pkg::BANK_ADDR_WIDTH-1:0] addr,
    input  logic [hist_pkg::DATA_WIDTH-1:0]     data,
    input  logic [hist_pkg::DATA_WIDTH-1:0]     din,
    input  logic                                operation,

    input  logic                                max_clear,

    output logic [hist_pkg::DATA_WIDTH-1:0]     dout,
    output logic [hist_pkg::BANK_ADDR_WIDTH-1:0] max_addr,
    output logic [hist_pkg::DATA_WIDTH-1:0]     max_data
);

    // stage 0
    logic                                 st0_we;
    logic                                 st0_valid;
    logic [hist_pkg::BANK_ADDR_WIDTH-1:0] st0_addr;
    logic [hist_pkg::DATA_WIDTH-1:0]      st0_din;
    logic [hist_pkg::DATA_WIDTH-1:0]      st0_data;
    logic                                 st0_operation;

    // stage 1
    logic                                 st1_valid;
    logic                                 st1_fw_st2;
    logic                                 st1_fw_st3;
    logic [hist_pkg::BANK_ADDR_WIDTH-1:0] st1_addr;
    logic [hist_pkg::DATA_WIDTH-1:0]      st1_data;
    logic                                 st1_operation;
    logic [hist_pkg::DATA_WIDTH-1:0]      st1_dout;
    logic [hist_pkg::DATA_WIDTH-1:0]      st1_rdata;

    // stage 2 and the copy of the previous write
    logic                                 st2_valid;
    logic [hist_pkg::BANK_ADDR_WIDTH-1:0] st2_addr;
    logic [hist_pkg::DATA_WIDTH-1:0]      st2_data;
    logic [hist_pkg::DATA_WIDTH-1:0]      st3_data;

    // --------------------------------------------------
    // control state
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            st0_we     <= 1'b0;
            st0_valid  <= 1'b0;
            st1_valid  <= 1'b0;
            st1_fw_st2 <= 1'b0;
            st1_fw_st3 <= 1'b0;
            st2_valid  <= 1'b0;
        end else begin
            st0_we     <= mem_en && mem_we;
            st0_valid  <= acc_valid;
            st1_valid  <= st0_valid;
            // the vote now in stage 1 will be in stage 2 next cycle
            st1_fw_st2 <= st0_valid && st1_valid && (st0_addr == st1_addr);
            // and the one in stage 2 will have written, held in st3_data
            st1_fw_st3 <= st0_valid && st2_valid && (st0_addr == st2_addr);
            st2_valid  <= st1_valid;
        end
    end

    // --------------------------------------------------
    // payload pipeline
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        st0_addr      <= addr;
        st0_din       <= din;
        st0_data      <= data;
        st0_operation <= operation;

        st1_addr      <= st0_addr;
        st1_data      <= st0_data;
        st1_operation <= st0_operation;

        st2_addr      <= st1_addr;
        if (st1_operation == hist_pkg::OP_ADD) begin
            st2_data <= st1_rdata + st1_data;
        end else begin
            st2_data <= st1_rdata - st1_data;
        end

        st3_data      <= st2_data;
    end

    // newest matching result wins over older ones and over RAM
    always_comb begin
        if (st1_fw_st2) begin
            st1_rdata = st2_data;
        end else if (st1_fw_st3) begin
            st1_rdata = st3_data;
        end else begin
            st1_rdata = st1_dout;
        end
    end

    // --------------------------------------------------
    // bin memory
    // --------------------------------------------------

    hist_bank_ram u_hist_bank_ram (
        .clk    (clk),
        .a_we   (st0_we),
        .a_addr (st0_addr),
        .a_din  (st0_din),
        .a_dout (st1_dout),
        .b_we   (st2_valid),
        .b_addr (st2_addr),
        .b_din  (st2_data)
    );

    // host read data, sampled by the merge block at the right cycle
    assign dout = st1_dout;

    // --------------------------------------------------
    // running maximum
    // --------------------------------------------------

    // strictly greater, so the earliest write keeps a tie
    always_ff @(posedge clk) begin
        if (reset || max_clear) begin
            max_addr <= '0;
            max_data <= '0;
        end else if (st2_valid && (st2_data > max_data)) begin
            max_addr <= st2_addr;
            max_data <= st2_data;
        end
    end

endmodule

//--- hist_bank/hist_bank_ram.sv
// dual-port bin memory for one bank: registered read on port A, writes on both ports
module hist_bank_ram (
    input  logic                                clk,

    // port A, host write or pipeline read
    input  logic                                a_we,
    input  logic [hist_pkg::BANK_ADDR_WIDTH-1:0] a_addr,
    input  logic [hist_pkg::DATA_WIDTH-1:0]     a_din,
    output logic [hist_pkg::DATA_WIDTH-1:0]     a_dout,

    // port B, write-back of accumulated result
    input  logic                                b_we,
    input  logic [hist_pkg::BANK_ADDR_WIDTH-1:0] b_addr,
    input  logic [hist_pkg::DATA_WIDTH-1:0]     b_din
);

    logic [hist_pkg::DATA_WIDTH-1:0] mem [hist_pkg::BANK_DEPTH];

    // --------------------------------------------------
    // port A
    // --------------------------------------------------

    // read returns the old word when port B writes the same address this edge
    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_din;
        end
        a_dout <= mem[a_addr];
        // port B write is placed after port A, so it wins on a collision
        if (b_we) begin
            mem[b_addr] <= b_din;
        end
    end

endmodule

//--- hw/hist_accum_top.sv
// top level of the banked histogram accumulator: dispatcher, bank array and merge stage
module hist_accum_top (
    input  logic                            clk,
    input  logic                            reset,

    // vote stream
    input  logic                            acc_valid,
    input  logic [hist_pkg::BIN_WIDTH-1:0]  acc_bin,
    input  logic [hist_pkg::DATA_WIDTH-1:0] acc_data,
    input  logic                            acc_operation,

    // host access
    input  logic                            mem_en,
    input  logic                            mem_we,
    input  logic [hist_pkg::BIN_WIDTH-1:0]  mem_bin,
    input  logic [hist_pkg::DATA_WIDTH-1:0] mem_din,
    input  logic                            max_clear,

    output logic [hist_pkg::DATA_WIDTH-1:0] mem_dout,
    output logic [hist_pkg::BIN_WIDTH-1:0]  max_bin,
    output logic [hist_pkg::DATA_WIDTH-1:0] max_data
);

    // dispatcher to banks
    logic [hist_pkg::NUM_BANKS-1:0]       bank_acc_valid;
    logic [hist_pkg::NUM_BANKS-1:0]       bank_mem_en;
    logic                                 bank_mem_we;
    logic [hist_pkg::BANK_ADDR_WIDTH-1:0] bank_addr;
    logic [hist_pkg::DATA_WIDTH-1:0]      bank_data;
    logic [hist_pkg::DATA_WIDTH-1:0]      bank_din;
    logic                                 bank_operation;

    // dispatcher to merge
    logic [hist_pkg::BANK_SEL_WIDTH-1:0]  rd_sel;
    logic                                 rd_pending;

    // banks to merge, flattened
    logic [hist_pkg::NUM_BANKS*hist_pkg::DATA_WIDTH-1:0]      bank_dout;
    logic [hist_pkg::NUM_BANKS*hist_pkg::BANK_ADDR_WIDTH-1:0] bank_max_addr;
    logic [hist_pkg::NUM_BANKS*hist_pkg::DATA_WIDTH-1:0]      bank_max_data;

    hist_dispatch u_hist_dispatch (
        .clk            (clk),
        .reset          (reset),
        .acc_valid      (acc_valid),
        .acc_bin        (acc_bin),
        .acc_data       (acc_data),
        .acc_operation  (acc_operation),
        .mem_en         (mem_en),
        .mem_we         (mem_we),
        .mem_bin        (mem_bin),
        .mem_din        (mem_din),
        .bank_acc_valid (bank_acc_valid),
        .bank_mem_en    (bank_mem_en),
        .bank_mem_we    (bank_mem_we),
        .bank_addr      (bank_addr),
        .bank_data      (bank_data),
        .bank_din       (bank_din),
        .bank_operation (bank_operation),
        .rd_sel         (rd_sel),
        .rd_pending     (rd_pending)
    );

    // --------------------------------------------------
    // bank array
    // --------------------------------------------------

    for (genvar g = 0; g < hist_pkg::NUM_BANKS; g++) begin : g_bank
        hist_bank u_hist_bank (
            .clk       (clk),
            .reset     (reset),
            .acc_valid (bank_acc_valid[g]),
            .mem_en    (bank_mem_en[g]),
            .mem_we    (bank_mem_we),
            .addr      (bank_addr),
            .data      (bank_data),
            .din       (bank_din),
            .operation (bank_operation),
            .max_clear (max_clear),
            .dout      (bank_dout[g*hist_pkg::DATA_WIDTH +: hist_pkg::DATA_WIDTH]),
            .max_addr  (bank_max_addr[g*hist_pkg::BANK_ADDR_WIDTH +: hist_pkg::BANK_ADDR_WIDTH]),
            .max_data  (bank_max_data[g*hist_pkg::DATA_WIDTH +: hist_pkg::DATA_WIDTH])
        );
    end

    hist_max_merge u_hist_max_merge (
        .clk           (clk),
        .reset         (reset),
        .max_clear     (max_clear),
        .bank_dout     (bank_dout),
        .bank_max_addr (bank_max_addr),
        .bank_max_data (bank_max_data),
        .rd_sel        (rd_sel),
        .rd_pending    (rd_pending),
        .mem_dout      (mem_dout),
        .max_bin       (max_bin),
        .max_data      (max_data)
    );

endmodule

//--- hw/hist_dispatch.sv
// input register of the accumulator: routes votes and host accesses to one bank per cycle
module hist_dispatch (
    input  logic                                  clk,
    input  logic                                  reset,

    // vote stream
    input  logic                                  acc_valid,
    input  logic [hist_pkg::BIN_WIDTH-1:0]        acc_bin,
    input  logic [hist_pkg::DATA_WIDTH-1:0]       acc_data,
    input  logic                                  acc_operation,

    // host access
    input  logic                                  mem_en,
    input  logic                                  mem_we,
    input  logic [hist_pkg::BIN_WIDTH-1:0]        mem_bin,
    input  logic [hist_pkg::DATA_WIDTH-1:0]       mem_din,

    // to the banks
    output logic [hist_pkg::NUM_BANKS-1:0]        bank_acc_valid,
    output logic [hist_pkg::NUM_BANKS-1:0]        bank_mem_en,
    output logic                                  bank_mem_we,
    output logic [hist_pkg::BANK_ADDR_WIDTH-1:0]  bank_addr,
    output logic [hist_pkg::DATA_WIDTH-1:0]       bank_data,
    output logic [hist_pkg::DATA_WIDTH-1:0]       bank_din,
    output logic                                  bank_operation,

    // to the merge block
    output logic [hist_pkg::BANK_SEL_WIDTH-1:0]   rd_sel,
    output logic                                  rd_pending
);

    logic [hist_pkg::BANK_SEL_WIDTH-1:0]  acc_sel;
    logic [hist_pkg::BANK_ADDR_WIDTH-1:0] acc_local;
    logic [hist_pkg::BANK_SEL_WIDTH-1:0]  mem_sel;
    logic [hist_pkg::BANK_ADDR_WIDTH-1:0] mem_local;

    // low bits pick the bank, high bits the word inside it
    assign acc_sel   = acc_bin[hist_pkg::BANK_SEL_WIDTH-1:0];
    assign acc_local = acc_bin[hist_pkg::BIN_WIDTH-1:hist_pkg::BANK_SEL_WIDTH];
    assign mem_sel   = mem_bin[hist_pkg::BANK_SEL_WIDTH-1:0];
    assign mem_local = mem_bin[hist_pkg::BIN_WIDTH-1:hist_pkg::BANK_SEL_WIDTH];

    // --------------------------------------------------
    // strobes
    // --------------------------------------------------

    // host access wins, a vote in the same cycle is lost
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_acc_valid <= '0;
            bank_mem_en    <= '0;
            rd_pending     <= 1'b0;
        end else begin
            bank_acc_valid <= '0;
            bank_mem_en    <= '0;
            if (mem_en) begin
                bank_mem_en[mem_sel] <= 1'b1;
            end else if (acc_valid) begin
                bank_acc_valid[acc_sel] <= 1'b1;
            end
            rd_pending <= mem_en && !mem_we;
        end
    end

    // --------------------------------------------------
    // shared buses
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        bank_mem_we    <= mem_we;
        bank_addr      <= mem_en ? mem_local : acc_local;
        bank_data      <= acc_data;
        bank_din       <= mem_din;
        bank_operation <= acc_operation;
        rd_sel         <= mem_sel;
    end

endmodule

//--- hw/hist_max_merge.sv
// output stage: global maximum across banks and host read data return
module hist_max_merge (
    input  logic                                                     clk,
    input  logic                                                     reset,
    input  logic                                                     max_clear,

    // flattened per-bank outputs, bank 0 in the low slice
    input  logic [hist_pkg::NUM_BANKS*hist_pkg::DATA_WIDTH-1:0]      bank_dout,
    input  logic [hist_pkg::NUM_BANKS*hist_pkg::BANK_ADDR_WIDTH-1:0] bank_max_addr,
    input  logic [hist_pkg::NUM_BANKS*hist_pkg::DATA_WIDTH-1:0]      bank_max_data,

    // host read tracking from the dispatcher
    input  logic [hist_pkg::BANK_SEL_WIDTH-1:0]                      rd_sel,
    input  logic                                                     rd_pending,

    output logic [hist_pkg::DATA_WIDTH-1:0]                          mem_dout,
    output logic [hist_pkg::BIN_WIDTH-1:0]                           max_bin,
    output logic [hist_pkg::DATA_WIDTH-1:0]                          max_data
);

    logic [hist_pkg::BANK_SEL_WIDTH-1:0]  rd_sel_d1;
    logic [hist_pkg::BANK_SEL_WIDTH-1:0]  rd_sel_d2;
    logic                                 rd_pending_d1;
    logic                                 rd_pending_d2;

    logic [hist_pkg::BANK_SEL_WIDTH-1:0]  best_sel;
    logic [hist_pkg::BANK_ADDR_WIDTH-1:0] best_addr;
    logic [hist_pkg::DATA_WIDTH-1:0]      best_data;

    // --------------------------------------------------
    // host read return
    // --------------------------------------------------

    // two cycles: bank stage 0, then the RAM output register
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending_d1 <= 1'b0;
            rd_pending_d2 <= 1'b0;
        end else begin
            rd_pending_d1 <= rd_pending;
            rd_pending_d2 <= rd_pending_d1;
        end
    end

    always_ff @(posedge clk) begin
        rd_sel_d1 <= rd_sel;
        rd_sel_d2 <= rd_sel_d1;
        // held until the next read
        if (rd_pending_d2) begin
            mem_dout <= bank_dout[rd_sel_d2*hist_pkg::DATA_WIDTH +: hist_pkg::DATA_WIDTH];
        end
    end

    // --------------------------------------------------
    // maximum reduction
    // --------------------------------------------------

    // strict compare keeps the lowest bank on a tie
    always_comb begin
        best_sel  = '0;
        best_addr = bank_max_addr[0 +: hist_pkg::BANK_ADDR_WIDTH];
        best_data = bank_max_data[0 +: hist_pkg::DATA_WIDTH];
        for (int i = 1; i < hist_pkg::NUM_BANKS; i++) begin
            if (bank_max_data[i*hist_pkg::DATA_WIDTH +: hist_pkg::DATA_WIDTH] > best_data) begin
                best_sel  = i[hist_pkg::BANK_SEL_WIDTH-1:0];
                best_addr = bank_max_addr[i*hist_pkg::BANK_ADDR_WIDTH +: hist_pkg::BANK_ADDR_WIDTH];
                best_data = bank_max_data[i*hist_pkg::DATA_WIDTH +: hist_pkg::DATA_WIDTH];
            end
        end
    end

    // global bin puts the bank index back in the low bits
    always_ff @(posedge clk) begin
        if (reset || max_clear) begin
            max_bin  <= '0;
            max_data <= '0;
        end else begin
            max_bin  <= {best_addr, best_sel};
            max_data <= best_data;
        end
    end

endmodule

//--- sim.f
common/hist_pkg.sv
hist_bank/hist_bank_ram.sv
hist_bank/hist_bank.sv
hw/hist_dispatch.sv
hw/hist_max_merge.sv
hw/hist_accum_top.sv
testbench/tb_hist_accum.sv

//--- testbench/hist_stim.txt
# one command per line, decimal arguments: write bin value | vote bin weight op | read bin expected
# max bin value | hvote wbin wvalue vbin weight op | clear | idle cycles | test name | end
test host_rw
write 0 12345
write 5 262143
write 10 1
write 255 777
idle 4
read 0 12345
read 5 262143
read 10 1
read 255 777
write 5 0
write 255 0
idle 4
read 5 0
read 255 0
end
test distinct_votes
write 16 0
write 17 0
write 18 0
write 19 262000
write 20 0
idle 4
vote 16 1000 0
vote 17 50000 0
vote 18 3000 0
vote 19 200 0
vote 20 7 0
vote 16 2000 0
vote 18 1000 1
vote 16 500 1
idle 8
read 16 2500
read 17 50000
read 18 2000
read 19 56
read 20 7
end
test forwarding
write 40 0
write 41 0
write 42 0
idle 4
# back to back on one bin
vote 40 100 0
vote 40 200 0
vote 40 300 0
# one idle cycle between votes
vote 41 1000 0
idle 1
vote 41 2000 0
idle 1
vote 41 500 1
# two idle cycles between votes
vote 42 40000 0
idle 2
vote 42 30000 0
idle 8
read 40 600
read 41 2500
read 42 70000
end
test maximum
max 42 70000
vote 42 60000 1
idle 8
read 42 10000
max 42 70000
clear
idle 2
max 0 0
vote 17 1 0
vote 20 100000 0
vote 40 5 0
idle 8
max 20 100007
read 17 50001
read 20 100007
end
test collision
hvote 33 4321 16 999 0
hvote 34 9 18 5 0
idle 6
read 33 4321
read 16 2500
read 34 9
read 18 2000
max 20 100007
end

//--- testbench/tb_hist_accum.sv
// testbench for the histogram accumulator, runs the command script testbench/hist_stim.txt
module tb_hist_accum;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT   = 1000;
    localparam int MAX_COMMANDS = 2000;
    localparam int LINE_LIMIT   = 512;

    logic                            clk;
    logic                            reset;
    logic                            acc_valid;
    logic [hist_pkg::BIN_WIDTH-1:0]  acc_bin;
    logic [hist_pkg::DATA_WIDTH-1:0] acc_data;
    logic                            acc_operation;
    logic                            mem_en;
    logic                            mem_we;
    logic [hist_pkg::BIN_WIDTH-1:0]  mem_bin;
    logic [hist_pkg::DATA_WIDTH-1:0] mem_din;
    logic                            max_clear;
    logic [hist_pkg::DATA_WIDTH-1:0] mem_dout;
    logic [hist_pkg::BIN_WIDTH-1:0]  max_bin;
    logic [hist_pkg::DATA_WIDTH-1:0] max_data;

    // per test and run totals
    int    checks;
    int    errors;
    int    total_checks;
    int    total_errors;
    int    tests_passed;
    int    tests_failed;
    bit    timed_out;
    bit    stim_error;
    string test_name;

    hist_accum_top u_hist_accum_top (
        .clk           (clk),
        .reset         (reset),
        .acc_valid     (acc_valid),
        .acc_bin       (acc_bin),
        .acc_data      (acc_data),
        .acc_operation (acc_operation),
        .mem_en        (mem_en),
        .mem_we        (mem_we),
        .mem_bin       (mem_bin),
        .mem_din       (mem_din),
        .max_clear     (max_clear),
        .mem_dout      (mem_dout),
        .max_bin       (max_bin),
        .max_data      (max_data)
    );

    always #20 clk = ~clk;

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------

    // counts falling edges, gives up past the limit
    task automatic wait_cycles(input int n, input string what);
        int count;
        count = 0;
        while (count < n) begin
            if (count >= WAIT_LIMIT) begin
                $display("timeout: %s did not finish within %0d cycles", what, WAIT_LIMIT);
                timed_out = 1'b1;
                break;
            end
            @(negedge clk);
            count++;
        end
    endtask

    task automatic compare_value(input string what, input int expected, input int actual);
        checks++;
        total_checks++;
        assert (actual == expected) else begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            errors++;
            total_errors++;
        end
    endtask

    task automatic write_bin(input int bin, input int value);
        mem_en  = 1'b1;
        mem_we  = 1'b1;
        mem_bin = bin[hist_pkg::BIN_WIDTH-1:0];
        mem_din = value[hist_pkg::DATA_WIDTH-1:0];
        wait_cycles(1, "host write");
        mem_en  = 1'b0;
        mem_we  = 1'b0;
    endtask

    task automatic send_vote(input int bin, input int weight, input int op);
        acc_valid     = 1'b1;
        acc_bin       = bin[hist_pkg::BIN_WIDTH-1:0];
        acc_data      = weight[hist_pkg::DATA_WIDTH-1:0];
        acc_operation = op[0];
        wait_cycles(1, "vote");
        acc_valid     = 1'b0;
    endtask

    // host write and vote in one cycle, the vote should be lost
    task automatic write_with_vote(input int wbin, input int wval, input int vbin,
                                   input int weight, input int op);
        acc_valid     = 1'b1;
        acc_bin       = vbin[hist_pkg::BIN_WIDTH-1:0];
        acc_data      = weight[hist_pkg::DATA_WIDTH-1:0];
        acc_operation = op[0];
        write_bin(wbin, wval);
        acc_valid     = 1'b0;
    endtask

    task automatic read_bin(input int bin, input int expected);
        mem_en  = 1'b1;
        mem_we  = 1'b0;
        mem_bin = bin[hist_pkg::BIN_WIDTH-1:0];
        wait_cycles(1, "host read strobe");
        mem_en  = 1'b0;
        wait_cycles(hist_pkg::READ_LATENCY - 1, "host read latency");
        compare_value($sformatf("read bin %0d", bin), expected, int'(mem_dout));
    endtask

    task automatic pulse_clear();
        max_clear = 1'b1;
        wait_cycles(1, "max clear");
        max_clear = 1'b0;
    endtask

    task automatic finish_test();
        if (errors == 0) begin
            $display("test %s: passed, %0d checks", test_name, checks);
            tests_passed++;
        end else begin
            $display("test %s: failed, %0d of %0d checks", test_name, errors, checks);
            tests_failed++;
        end
    endtask

    function automatic bit arg_count_ok(input int got, input int want, input string cmd);
        if (got != want) begin
            $display("malformed '%s' command in the stimulus file", cmd);
            stim_error = 1'b1;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic void skip_line(input int fd);
        int ch;
        int count;
        ch    = 0;
        count = 0;
        while (ch != 10 && ch != -1 && count < LINE_LIMIT) begin
            ch = $fgetc(fd);
            count++;
        end
    endfunction

    // --------------------------------------------------
    // command interpreter
    // --------------------------------------------------

    initial begin
        int    fd;
        int    code;
        int    n_cmd;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        string cmd;
        string name;

        clk           = 1'b0;
        reset         = 1'b1;
        acc_valid     = 1'b0;
        acc_bin       = '0;
        acc_data      = '0;
        acc_operation = hist_pkg::OP_ADD;
        mem_en        = 1'b0;
        mem_we        = 1'b0;
        mem_bin       = '0;
        mem_din       = '0;
        max_clear     = 1'b0;
        test_name     = "none";

        wait_cycles(16, "reset");
        reset = 1'b0;
        wait_cycles(2, "reset release");

        fd = $fopen("testbench/hist_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/hist_stim.txt");
            stim_error = 1'b1;
        end else begin
            n_cmd = 0;
            while (!timed_out) begin
                code = $fscanf(fd, "%s", cmd);
                if (code != 1) begin
                    break;
                end
                n_cmd++;
                if (n_cmd > MAX_COMMANDS) begin
                    $display("stimulus file has more than %0d commands, stopping", MAX_COMMANDS);
                    timed_out = 1'b1;
                    break;
                end
                if (cmd[0] == 8'h23) begin
                    skip_line(fd);
                    continue;
                end
                case (cmd)
                    "test": begin
                        code = $fscanf(fd, "%s", name);
                        test_name = name;
                        checks    = 0;
                        errors    = 0;
                    end
                    "end": finish_test();
                    "write": begin
                        code = $fscanf(fd, "%d %d", a, b);
                        if (arg_count_ok(code, 2, cmd)) write_bin(a, b);
                    end
                    "vote": begin
                        code = $fscanf(fd, "%d %d %d", a, b, c);
                        if (arg_count_ok(code, 3, cmd)) send_vote(a, b, c);
                    end
                    "hvote": begin
                        code = $fscanf(fd, "%d %d %d %d %d", a, b, c, d, e);
                        if (arg_count_ok(code, 5, cmd)) write_with_vote(a, b, c, d, e);
                    end
                    "read": begin
                        code = $fscanf(fd, "%d %d", a, b);
                        if (arg_count_ok(code, 2, cmd)) read_bin(a, b);
                    end
                    "max": begin
                        code = $fscanf(fd, "%d %d", a, b);
                        if (arg_count_ok(code, 2, cmd)) begin
                            compare_value("max_bin", a, int'(max_bin));
                            compare_value("max_data", b, int'(max_data));
                        end
                    end
                    "clear": pulse_clear();
                    "idle": begin
                        code = $fscanf(fd, "%d", a);
                        if (arg_count_ok(code, 1, cmd)) wait_cycles(a, "idle");
                    end
                    default: begin
                        $display("unknown command '%s' in the stimulus file", cmd);
                        stim_error = 1'b1;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, total_checks, total_errors);
        if (total_errors == 0 && tests_failed == 0 && !timed_out && !stim_error
            && total_checks > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
